// ==== compile.f ====
design/md_loader_pkg.sv
design/download_decode.sv
design/header_region_scan.sv
design/region_select.sv
design/cheat_code_loader.sv
design/cheat_patcher.sv
design/md_loader_top.sv
testbench/md_loader_assertions.sv
testbench/md_loader_tb.sv

// ==== design/cheat_code_loader.sv ====
// Collects the 16-bit words of a cheat file into one 128-bit code.
// Strobes the code out after its last word and clears the slots on a new file.

`timescale 1ns/1ps

module cheat_code_loader import md_loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        sys_reset,
	input  ioctl_t      ioctl_i,
	input  dl_kind_t    dl_kind_i,
	output cheat_code_t code_o,
	output logic        code_stb_o,
	output logic        clear_o
);

	cheat_code_t code_q;
	logic        stb_q;
	logic        clear_q;
	logic        code_wr;

	assign code_wr = dl_kind_i.code_dl & ioctl_i.wr;

	// Word placement, low half first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_i.addr[3:0])
				4'd0:  code_q.flags[15:0]    <= ioctl_i.data;
				4'd2:  code_q.flags[31:16]   <= ioctl_i.data;
				4'd4:  code_q.address[15:0]  <= ioctl_i.data;
				4'd6:  code_q.address[31:16] <= ioctl_i.data;
				4'd8:  code_q.compare[15:0]  <= ioctl_i.data;
				4'd10: code_q.compare[31:16] <= ioctl_i.data;
				4'd12: code_q.replace[15:0]  <= ioctl_i.data;
				4'd14: code_q.replace[31:16] <= ioctl_i.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			stb_q   <= 1'b0;
			clear_q <= 1'b0;
		end else begin
			stb_q   <= code_wr && ioctl_i.addr[3:0] == 4'd14;
			clear_q <= (code_wr && ioctl_i.addr == '0) | dl_kind_i.cart_start;
		end
	end

	assign code_o     = code_q;
	assign code_stb_o = stb_q;
	assign clear_o    = clear_q;

endmodule

// ==== design/cheat_patcher.sv ====
// Holds a few cheat codes and patches matching reads on one CPU bus.
// The bus type sets the address and data widths, so one block serves both CPUs.

`timescale 1ns/1ps

module cheat_patcher import md_loader_pkg::*; #(
	parameter type bus_t = m68k_bus_t
) (
	input  logic        clk_sys,
	input  logic        sys_reset,
	input  logic        enable_i,
	input  cheat_code_t code_i,
	input  logic        code_stb_i,
	input  logic        clear_i,
	input  bus_t        bus_i,
	output bus_t        bus_o,
	output logic        avail_o
);

	localparam int ADDR_W = $bits(bus_i.addr);
	localparam int DATA_W = $bits(bus_i.data);
	localparam int IDX_W  = (CHEAT_SLOTS > 1) ? $clog2(CHEAT_SLOTS) : 1;

	cheat_code_t             slot_code [CHEAT_SLOTS];
	logic [CHEAT_SLOTS-1:0]  slot_valid;
	logic [IDX_W-1:0]        free_idx;
	logic                    has_free;
	logic                    hit;
	logic [DATA_W-1:0]       hit_data;
	bus_t                    bus_q;

	//////////////////////////////////////////////////////////////////////
	// Slot fill
	//////////////////////////////////////////////////////////////////////

	// Slots fill in order, so the lowest empty one is next
	always_comb begin
		free_idx = '0;
		has_free = 1'b0;
		for (int i = CHEAT_SLOTS - 1; i >= 0; i--) begin
			if (!slot_valid[i]) begin
				free_idx = IDX_W'(i);
				has_free = 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset || clear_i)
			slot_valid <= '0;
		else if (code_stb_i && has_free)
			slot_valid[free_idx] <= 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (code_stb_i && has_free && !clear_i)
			slot_code[free_idx] <= code_i;
	end

	//////////////////////////////////////////////////////////////////////
	// Lookup, lowest matching slot wins
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		hit      = 1'b0;
		hit_data = bus_i.data;
		for (int i = CHEAT_SLOTS - 1; i >= 0; i--) begin
			if (slot_valid[i] &&
			    slot_code[i].address[ADDR_W-1:0] == bus_i.addr &&
			    (!slot_code[i].flags[0] || slot_code[i].compare[DATA_W-1:0] == bus_i.data)) begin
				hit      = 1'b1;
				hit_data = slot_code[i].replace[DATA_W-1:0];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		bus_q.addr <= bus_i.addr;
		bus_q.data <= (enable_i && hit) ? hit_data : bus_i.data;
	end

	assign bus_o   = bus_q;
	assign avail_o = |slot_valid;

endmodule

// ==== design/download_decode.sv ====
// Decodes the download file index into cartridge and cheat kinds.
// Holds the cartridge kind for the whole download and makes start/end pulses.

`timescale 1ns/1ps

module download_decode import md_loader_pkg::*; (
	input  logic     clk_sys,
	input  logic     sys_reset,
	input  ioctl_t   ioctl_i,
	output dl_kind_t dl_kind_o
);

	logic cart_dl;
	logic code_dl;
	logic cart_dl_d;
	logic cart_ms_q;
	logic start_q;
	logic end_q;

	// Index 1 is a main console image, 2 a master-system image
	assign cart_dl = ioctl_i.download &
		(ioctl_i.index[4:0] == 5'd1 || ioctl_i.index[4:0] == 5'd2);
	assign code_dl = ioctl_i.download & (&ioctl_i.index);

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			cart_dl_d <= 1'b0;
			cart_ms_q <= 1'b0;
			start_q   <= 1'b0;
			end_q     <= 1'b0;
		end else begin
			cart_dl_d <= cart_dl;
			start_q   <= cart_dl & ~cart_dl_d;
			end_q     <= ~cart_dl & cart_dl_d;
			// Kind latched once per download
			if (cart_dl & ~cart_dl_d)
				cart_ms_q <= (ioctl_i.index[4:0] == 5'd2);
		end
	end

	always_comb begin
		dl_kind_o.cart_dl    = cart_dl;
		dl_kind_o.code_dl    = code_dl;
		dl_kind_o.cart_ms    = cart_ms_q;
		dl_kind_o.cart_start = start_q;
		dl_kind_o.cart_end   = end_q;
	end

endmodule

// ==== design/header_region_scan.sv ====
// Watches cartridge writes for the region field of the header.
// Sets the J/U/E flags and raises header-ready once the header has passed.

`timescale 1ns/1ps

module header_region_scan import md_loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       sys_reset,
	input  ioctl_t     ioctl_i,
	input  dl_kind_t   dl_kind_i,
	output hdr_flags_t hdr_flags_o,
	output logic       hdr_ready_o
);

	hdr_flags_t flags_q;
	logic       ready_q;
	logic       hdr_wr;
	logic [7:0] lo_byte;
	logic [7:0] hi_byte;
	logic [3:0] hex_rgn;

	assign hdr_wr  = ioctl_i.wr & dl_kind_i.cart_dl;
	assign lo_byte = ioctl_i.data[7:0];
	assign hi_byte = ioctl_i.data[15:8];
	// Hex letters A..F, nibble 1..6 maps to 0xA..0xF
	assign hex_rgn = lo_byte[3:0] - 4'd7;

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			flags_q <= '0;
			ready_q <= 1'b0;
		end else begin
			if (dl_kind_i.cart_start)
				flags_q <= '0;
			if (dl_kind_i.cart_end)
				ready_q <= 1'b0;

			if (hdr_wr && ioctl_i.addr == HDR_REGION_ADDR) begin
				if (lo_byte == "J")
					flags_q.j <= 1'b1;
				else if (lo_byte == "U")
					flags_q.u <= 1'b1;
				else if (lo_byte == "E")
					flags_q.e <= 1'b1;
				else if (lo_byte >= "0" && lo_byte <= "9")
					{flags_q.e, flags_q.u, flags_q.j} <= {lo_byte[3], lo_byte[2], lo_byte[0]};
				else if (lo_byte >= "A" && lo_byte <= "F")
					{flags_q.e, flags_q.u, flags_q.j} <= {hex_rgn[3], hex_rgn[2], hex_rgn[0]};

				// High byte may carry a second letter
				if (hi_byte == "J")
					flags_q.j <= 1'b1;
				else if (hi_byte == "U")
					flags_q.u <= 1'b1;
				else if (hi_byte == "E")
					flags_q.e <= 1'b1;
			end

			if (hdr_wr && ioctl_i.addr == HDR_REGION2_ADDR) begin
				if (lo_byte == "J")
					flags_q.j <= 1'b1;
				else if (lo_byte == "U")
					flags_q.u <= 1'b1;
				else if (lo_byte == "E")
					flags_q.e <= 1'b1;
			end

			if (hdr_wr && ioctl_i.addr == HDR_END_ADDR)
				ready_q <= 1'b1;
		end
	end

	assign hdr_flags_o = flags_q;
	assign hdr_ready_o = ready_q;

endmodule

// ==== design/md_loader_pkg.sv ====
// Shared widths, header addresses and types for the cartridge and cheat loader.
// Every RTL block takes what it needs from here by a wildcard import.

package md_loader_pkg;

	//////////////////////////////////////////////////////////////////////
	// Download port and header layout
	//////////////////////////////////////////////////////////////////////

	localparam int IOCTL_ADDR_W = 25;
	localparam int IOCTL_DATA_W = 16;

	// Word addresses inside the cartridge header
	localparam logic [IOCTL_ADDR_W-1:0] HDR_REGION_ADDR  = 25'h1F0;
	localparam logic [IOCTL_ADDR_W-1:0] HDR_REGION2_ADDR = 25'h1F2;
	localparam logic [IOCTL_ADDR_W-1:0] HDR_END_ADDR     = 25'h200;

	localparam int CHEAT_SLOTS  = 4;
	localparam int CHEAT_CODE_W = 128;

	// Auto region modes
	localparam logic [1:0] AUTO_HEADER   = 2'd0;
	localparam logic [1:0] AUTO_FILE_EXT = 2'd1;
	localparam logic [1:0] AUTO_DISABLED = 2'd2;

	typedef struct packed {
		logic                    download;
		logic                    wr;
		logic [7:0]              index;
		logic [IOCTL_ADDR_W-1:0] addr;
		logic [IOCTL_DATA_W-1:0] data;
	} ioctl_t;

	typedef struct packed {
		logic cart_dl;
		logic code_dl;
		logic cart_ms;
		logic cart_start;
		logic cart_end;
	} dl_kind_t;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	typedef struct packed {
		logic j;
		logic u;
		logic e;
	} hdr_flags_t;

	//////////////////////////////////////////////////////////////////////
	// Cheat code and CPU bus views
	//////////////////////////////////////////////////////////////////////

	// Flags bit 0 enables the compare value
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic [23:0] addr;
		logic [15:0] data;
	} m68k_bus_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
	} z80_bus_t;

endpackage

// ==== design/md_loader_top.sv ====
// Top of the cartridge and cheat loading path.
// Decodes downloads, scans the header for a region and patches both CPU buses.

`timescale 1ns/1ps

module md_loader_top import md_loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       sys_reset,
	input  ioctl_t     ioctl_i,
	input  logic [1:0] auto_mode_i,
	input  logic [1:0] prio_i,
	input  logic       cheats_en_i,
	input  m68k_bus_t  m68k_bus_i,
	input  z80_bus_t   z80_bus_i,
	output m68k_bus_t  m68k_bus_o,
	output z80_bus_t   z80_bus_o,
	output region_e    region_o,
	output logic       region_set_o,
	output logic       cart_ms_o,
	output logic       cheats_avail_o
);

	dl_kind_t    dl_kind;
	hdr_flags_t  hdr_flags;
	logic        hdr_ready;
	cheat_code_t code;
	logic        code_stb;
	logic        clear;

	//////////////////////////////////////////////////////////////////////
	// Decode and header scan
	//////////////////////////////////////////////////////////////////////

	download_decode decode_i (
		.clk_sys   (clk_sys),
		.sys_reset (sys_reset),
		.ioctl_i   (ioctl_i),
		.dl_kind_o (dl_kind)
	);

	header_region_scan scan_i (
		.clk_sys     (clk_sys),
		.sys_reset   (sys_reset),
		.ioctl_i     (ioctl_i),
		.dl_kind_i   (dl_kind),
		.hdr_flags_o (hdr_flags),
		.hdr_ready_o (hdr_ready)
	);

	region_select region_i (
		.clk_sys       (clk_sys),
		.sys_reset     (sys_reset),
		.dl_kind_i     (dl_kind),
		.hdr_flags_i   (hdr_flags),
		.hdr_ready_i   (hdr_ready),
		.ioctl_index_i (ioctl_i.index),
		.auto_mode_i   (auto_mode_i),
		.prio_i        (prio_i),
		.region_o      (region_o),
		.region_set_o  (region_set_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Cheat engine
	//////////////////////////////////////////////////////////////////////

	cheat_code_loader loader_i (
		.clk_sys    (clk_sys),
		.sys_reset  (sys_reset),
		.ioctl_i    (ioctl_i),
		.dl_kind_i  (dl_kind),
		.code_o     (code),
		.code_stb_o (code_stb),
		.clear_o    (clear)
	);

	// 68k patches main console carts only
	cheat_patcher #(.bus_t(m68k_bus_t)) m68k_patch_i (
		.clk_sys    (clk_sys),
		.sys_reset  (sys_reset),
		.enable_i   (cheats_en_i & ~dl_kind.cart_ms),
		.code_i     (code),
		.code_stb_i (code_stb),
		.clear_i    (clear),
		.bus_i      (m68k_bus_i),
		.bus_o      (m68k_bus_o),
		.avail_o    (cheats_avail_o)
	);

	cheat_patcher #(.bus_t(z80_bus_t)) z80_patch_i (
		.clk_sys    (clk_sys),
		.sys_reset  (sys_reset),
		.enable_i   (cheats_en_i & dl_kind.cart_ms),
		.code_i     (code),
		.code_stb_i (code_stb),
		.clear_i    (clear),
		.bus_i      (z80_bus_i),
		.bus_o      (z80_bus_o),
		.avail_o    ()
	);

	assign cart_ms_o = dl_kind.cart_ms;

endmodule

// ==== design/region_select.sv ====
// Picks the console region when the header becomes ready.
// Uses the header flags in priority order, or the file extension bits of the index.

`timescale 1ns/1ps

module region_select import md_loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       sys_reset,
	input  dl_kind_t   dl_kind_i,
	input  hdr_flags_t hdr_flags_i,
	input  logic       hdr_ready_i,
	input  logic [7:0] ioctl_index_i,
	input  logic [1:0] auto_mode_i,
	input  logic [1:0] prio_i,
	output region_e    region_o,
	output logic       region_set_o
);

	logic    ready_d;
	region_e region_q;
	logic    set_q;

	// First set flag in priority order, default when none is set
	function automatic region_e pick_region(input logic [1:0] prio, input hdr_flags_t f);
		region_e r;
		case (prio)
			2'd0: r = f.u ? REGION_US : f.e ? REGION_EU : f.j ? REGION_JP : REGION_US;
			2'd1: r = f.e ? REGION_EU : f.u ? REGION_US : f.j ? REGION_JP : REGION_EU;
			2'd2: r = f.u ? REGION_US : f.j ? REGION_JP : f.e ? REGION_EU : REGION_US;
			default: r = f.j ? REGION_JP : f.u ? REGION_US : f.e ? REGION_EU : REGION_JP;
		endcase
		return r;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			ready_d  <= 1'b0;
			region_q <= REGION_JP;
			set_q    <= 1'b0;
		end else begin
			ready_d <= hdr_ready_i;
			if (hdr_ready_i & ~ready_d & ~dl_kind_i.cart_ms) begin
				case (auto_mode_i)
					AUTO_HEADER: begin
						region_q <= pick_region(prio_i, hdr_flags_i);
						set_q    <= 1'b1;
					end
					AUTO_FILE_EXT: begin
						region_q <= region_e'(ioctl_index_i[7:6]);
						set_q    <= |ioctl_index_i;
					end
					default: ;
				endcase
			end
			if (~hdr_ready_i & ready_d)
				set_q <= 1'b0;
		end
	end

	assign region_o     = region_q;
	assign region_set_o = set_q;

endmodule

// ==== testbench/md_loader_assertions.sv ====
// Concurrent assertions on the loader top level, attached with bind.
// Checks reset values, legal region codes and a steady cartridge kind.

`timescale 1ns/1ps

module md_loader_assertions (
	input logic       clk_sys,
	input logic       sys_reset,
	input logic [1:0] region_i,
	input logic       region_set_i,
	input logic       cheats_avail_i,
	input logic       cart_ms_i,
	input logic       cart_dl_i
);

	// Outputs start low once reset is released
	assert property (@(posedge clk_sys) $fell(sys_reset) |-> !region_set_i && !cheats_avail_i)
		else $error("region_set or cheats_avail high right after reset");

	assert property (@(posedge clk_sys) disable iff (sys_reset) region_i != 2'd3)
		else $error("region output holds the unused code 3");

	// Kind is latched on the start edge, so skip the first two cycles
	assert property (@(posedge clk_sys) disable iff (sys_reset)
		cart_dl_i && $past(cart_dl_i) && $past(cart_dl_i, 2) |-> $stable(cart_ms_i))
		else $error("cart_ms changed during a cartridge download");

endmodule

bind md_loader_top md_loader_assertions assertions_i (
	.clk_sys        (clk_sys),
	.sys_reset      (sys_reset),
	.region_i       (region_o),
	.region_set_i   (region_set_o),
	.cheats_avail_i (cheats_avail_o),
	.cart_ms_i      (cart_ms_o),
	.cart_dl_i      (dl_kind.cart_dl)
);

// ==== testbench/md_loader_tb.sv ====
// Testbench for the cartridge and cheat loading path.
// Runs a table of header downloads, then loads cheat codes and probes both CPU buses.

`timescale 1ns/1ps

module md_loader_tb import md_loader_pkg::*; ();

	localparam int CLK_PERIOD    = 8;
	localparam int RESET_CYCLES  = 16;
	localparam int ENTRY_CYCLES  = 32;
	localparam int MARGIN_CYCLES = 400;

	// Header words, high byte then low byte in ASCII
	localparam logic [15:0] HDR_J    = 16'h204A;
	localparam logic [15:0] HDR_U    = 16'h2055;
	localparam logic [15:0] HDR_E    = 16'h2045;
	localparam logic [15:0] HDR_EU   = 16'h4555;
	localparam logic [15:0] HDR_NONE = 16'h2020;

	localparam cheat_code_t CODE_A = '{32'h1, 32'h00FF10, 32'h1234, 32'hABCD5678};
	localparam cheat_code_t CODE_B = '{32'h0, 32'h001000, 32'h0, 32'h0000BEEF};
	localparam cheat_code_t CODE_Z = '{32'h0, 32'h000C00, 32'h0, 32'h000012A5};

	typedef struct packed {
		logic [7:0]  index;
		logic [15:0] word0;
		logic [15:0] word1;
		logic [1:0]  auto_mode;
		logic [1:0]  prio;
		region_e     exp_region;
		logic        exp_set;
	} entry_t;

	logic        clk_sys;
	logic        sys_reset;
	ioctl_t      ioctl;
	logic [1:0]  auto_mode;
	logic [1:0]  prio;
	logic        cheats_en;
	m68k_bus_t   m68k_bus_in;
	z80_bus_t    z80_bus_in;
	m68k_bus_t   m68k_bus_out;
	z80_bus_t    z80_bus_out;
	region_e     region;
	logic        region_set;
	logic        cart_ms;
	logic        cheats_avail;

	entry_t      entries[$];
	string       names[$];
	logic        table_ready = 1'b0;
	logic [15:0] lfsr_state  = 16'd24;
	int          n_checks    = 0;
	int          n_errors    = 0;

	md_loader_top dut_i (
		.clk_sys        (clk_sys),
		.sys_reset      (sys_reset),
		.ioctl_i        (ioctl),
		.auto_mode_i    (auto_mode),
		.prio_i         (prio),
		.cheats_en_i    (cheats_en),
		.m68k_bus_i     (m68k_bus_in),
		.z80_bus_i      (z80_bus_in),
		.m68k_bus_o     (m68k_bus_out),
		.z80_bus_o      (z80_bus_out),
		.region_o       (region),
		.region_set_o   (region_set),
		.cart_ms_o      (cart_ms),
		.cheats_avail_o (cheats_avail)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Galois LFSR, taps 16,14,13,11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic next_random(input int nbits, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic add_entry(input string name, input logic [7:0] index,
		input logic [15:0] word0, input logic [15:0] word1, input logic [1:0] mode,
		input logic [1:0] pr, input region_e exp_region, input logic exp_set);
		entries.push_back(entry_t'{index, word0, word1, mode, pr, exp_region, exp_set});
		names.push_back(name);
	endtask

	// Called on a falling edge, returns two falling edges later
	task automatic write_word(input logic [IOCTL_ADDR_W-1:0] addr, input logic [15:0] data);
		ioctl.addr = addr;
		ioctl.data = data;
		ioctl.wr   = 1'b1;
		@(negedge clk_sys);
		ioctl.wr = 1'b0;
		@(negedge clk_sys);
	endtask

	// Header download, returns two cycles after the 0x200 write
	task automatic load_cart(input logic [7:0] index, input logic [15:0] word0,
		input logic [15:0] word1);
		logic [31:0] fill;
		ioctl.index    = index;
		ioctl.download = 1'b1;
		repeat (3) @(negedge clk_sys);
		write_word(HDR_REGION_ADDR, word0);
		write_word(HDR_REGION2_ADDR, word1);
		for (int a = 'h1F4; a < 'h200; a += 2) begin
			next_random(16, fill);
			write_word(IOCTL_ADDR_W'(a), fill[15:0]);
		end
		write_word(HDR_END_ADDR, 16'h0000);
	endtask

	task automatic end_download();
		ioctl.download = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	// Eight words per code, flags low word first
	task automatic write_code(input int slot, input cheat_code_t c);
		int start;
		for (int i = 0; i < 8; i++) begin
			start = (3 - i / 2) * 32 + (i % 2) * 16;
			write_word(IOCTL_ADDR_W'(slot * 16 + 2 * i), c[start +: 16]);
		end
	endtask

	task automatic read_m68k(input string name, input logic [23:0] addr,
		input logic [15:0] data, input logic [15:0] expected);
		m68k_bus_in = '{addr, data};
		@(negedge clk_sys);
		check_equal({name, " data"}, expected, m68k_bus_out.data);
		check_equal({name, " addr"}, addr, m68k_bus_out.addr);
	endtask

	task automatic read_z80(input string name, input logic [15:0] addr,
		input logic [7:0] data, input logic [7:0] expected);
		z80_bus_in = '{addr, data};
		@(negedge clk_sys);
		check_equal({name, " data"}, expected, z80_bus_out.data);
		check_equal({name, " addr"}, addr, z80_bus_out.addr);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		int limit;
		wait (table_ready);
		limit = RESET_CYCLES + entries.size() * ENTRY_CYCLES + MARGIN_CYCLES;
		#(limit * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the run did not finish", limit);
		$display("tests failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		entry_t      e;
		sys_reset   = 1'b1;
		ioctl       = '0;
		auto_mode   = AUTO_HEADER;
		prio        = 2'd0;
		cheats_en   = 1'b0;
		m68k_bus_in = '0;
		z80_bus_in  = '0;

		// Header letters under each priority
		add_entry("j only prio0", 8'h01, HDR_J, HDR_NONE, AUTO_HEADER, 2'd0, REGION_JP, 1'b1);
		add_entry("j only prio1", 8'h01, HDR_J, HDR_NONE, AUTO_HEADER, 2'd1, REGION_JP, 1'b1);
		add_entry("j only prio2", 8'h01, HDR_J, HDR_NONE, AUTO_HEADER, 2'd2, REGION_JP, 1'b1);
		add_entry("j only prio3", 8'h01, HDR_J, HDR_NONE, AUTO_HEADER, 2'd3, REGION_JP, 1'b1);
		add_entry("ue prio0", 8'h01, HDR_EU, HDR_NONE, AUTO_HEADER, 2'd0, REGION_US, 1'b1);
		add_entry("ue prio1", 8'h01, HDR_EU, HDR_NONE, AUTO_HEADER, 2'd1, REGION_EU, 1'b1);
		add_entry("ue prio2", 8'h01, HDR_U, HDR_E, AUTO_HEADER, 2'd2, REGION_US, 1'b1);
		add_entry("ue prio3", 8'h01, HDR_U, HDR_E, AUTO_HEADER, 2'd3, REGION_US, 1'b1);
		add_entry("none prio0", 8'h01, HDR_NONE, HDR_NONE, AUTO_HEADER, 2'd0, REGION_US, 1'b1);
		add_entry("none prio1", 8'h01, HDR_NONE, HDR_NONE, AUTO_HEADER, 2'd1, REGION_EU, 1'b1);
		add_entry("none prio2", 8'h01, HDR_NONE, HDR_NONE, AUTO_HEADER, 2'd2, REGION_US, 1'b1);
		add_entry("none prio3", 8'h01, HDR_NONE, HDR_NONE, AUTO_HEADER, 2'd3, REGION_JP, 1'b1);
		// Digit and hex forms: '4' is U, 'A' is E, 'C' is U+E, '9' is J+E
		add_entry("digit 4", 8'h01, 16'h2034, HDR_NONE, AUTO_HEADER, 2'd3, REGION_US, 1'b1);
		add_entry("hex a", 8'h01, 16'h2041, HDR_NONE, AUTO_HEADER, 2'd0, REGION_EU, 1'b1);
		add_entry("hex c", 8'h01, 16'h2043, HDR_NONE, AUTO_HEADER, 2'd3, REGION_US, 1'b1);
		add_entry("digit 9", 8'h01, 16'h2039, HDR_NONE, AUTO_HEADER, 2'd2, REGION_JP, 1'b1);
		// Extension bits and the cases that leave the region alone
		add_entry("ext us", 8'h41, HDR_E, HDR_NONE, AUTO_FILE_EXT, 2'd0, REGION_US, 1'b1);
		add_entry("ext eu", 8'h81, HDR_E, HDR_NONE, AUTO_FILE_EXT, 2'd0, REGION_EU, 1'b1);
		add_entry("ext jp", 8'h01, HDR_E, HDR_NONE, AUTO_FILE_EXT, 2'd0, REGION_JP, 1'b1);
		add_entry("auto off", 8'h01, HDR_U, HDR_NONE, AUTO_DISABLED, 2'd0, REGION_JP, 1'b0);
		add_entry("ms header", 8'h02, HDR_J, HDR_NONE, AUTO_HEADER, 2'd3, REGION_JP, 1'b0);
		add_entry("ms ext", 8'h82, HDR_E, HDR_NONE, AUTO_FILE_EXT, 2'd0, REGION_EU, 1'b0);
		table_ready = 1'b1;

		repeat (RESET_CYCLES) @(negedge clk_sys);
		sys_reset = 1'b0;
		repeat (2) @(negedge clk_sys);

		foreach (entries[i]) begin
			e = entries[i];
			auto_mode = e.auto_mode;
			prio      = e.prio;
			load_cart(e.index, e.word0, e.word1);
			check_equal({names[i], " set"}, e.exp_set, region_set);
			if (e.exp_set)
				check_equal({names[i], " region"}, e.exp_region, region);
			check_equal({names[i], " cart_ms"}, e.index[4:0] == 5'd2, cart_ms);
			end_download();
		end

		// Two codes on a main console cart
		auto_mode = AUTO_DISABLED;
		cheats_en = 1'b1;
		load_cart(8'h01, HDR_NONE, HDR_NONE);
		end_download();
		ioctl.index    = 8'hFF;
		ioctl.download = 1'b1;
		@(negedge clk_sys);
		write_code(0, CODE_A);
		write_code(1, CODE_B);
		end_download();
		check_equal("cheats loaded avail", 1, cheats_avail);
		read_m68k("compare hit", 24'h00FF10, 16'h1234, 16'h5678);
		read_m68k("compare miss", 24'h00FF10, 16'h1111, 16'h1111);
		next_random(16, r);
		read_m68k("no compare", 24'h001000, r[15:0], 16'hBEEF);
		repeat (8) begin
			next_random(24, r);
			// Bit 23 set keeps the address clear of both slots
			m68k_bus_in.addr = r[23:0] | 24'h800000;
			next_random(16, r);
			read_m68k("random pass", m68k_bus_in.addr, r[15:0], r[15:0]);
		end

		cheats_en = 1'b0;
		read_m68k("cheats off", 24'h00FF10, 16'h1234, 16'h1234);
		cheats_en = 1'b1;

		// New cart empties the slots
		load_cart(8'h01, HDR_NONE, HDR_NONE);
		end_download();
		check_equal("slots cleared avail", 0, cheats_avail);
		read_m68k("slots cleared", 24'h001000, 16'h4321, 16'h4321);

		// Master-system cart moves patching to the Z80
		load_cart(8'h02, HDR_NONE, HDR_NONE);
		end_download();
		check_equal("ms cart kind", 1, cart_ms);
		ioctl.index    = 8'hFF;
		ioctl.download = 1'b1;
		@(negedge clk_sys);
		write_code(0, CODE_Z);
		end_download();
		read_z80("z80 patch", 16'h0C00, 8'h33, 8'hA5);
		read_z80("z80 other addr", 16'h0C01, 8'h33, 8'h33);
		read_m68k("m68k on ms cart", 24'h000C00, 16'h0033, 16'h0033);

		$display("checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
